//--- build.f
ray_pkg.sv
ray_mem.sv
ray_loader_wb.sv
ray_store_arb.sv
client_pipe.sv
raystore.sv
tb_raystore.sv

//--- Makefile
SIM = obj_dir/Vtb_raystore

all: run

$(SIM): build.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_raystore -f build.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module tb_raystore -f build.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- tb_raystore.sv
// default parameters only, requests use loaded ray ids only, and rsp_stall is random at one cycle in four
`default_nettype none

module tb_raystore;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int N_LOAD = 32;
	localparam int PER_CLIENT = 150;
	localparam int N_COMMIT = 8;
	localparam int LOAD_CYC = 45;
	localparam int WATCHDOG_CYC = 16 + N_LOAD * LOAD_CYC + (4 * PER_CLIENT + 4) * 40 + 200;

	logic        clk;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	// client order is trav0, trav1, lcache, list
	ray_pkg::rs_req_t req [4];
	logic [3:0]       req_valid;
	logic [3:0]       req_stall;
	ray_pkg::rs_rsp_t rsp [4];
	logic [3:0]       rsp_valid;
	logic [3:0]       rsp_stall;

	ray_pkg::ray_vec_u model [512];
	ray_pkg::ray_vec_u stage_model;
	ray_pkg::rs_rsp_t  exp_q [4][$];
	logic [8:0]        loaded_id [N_LOAD];
	logic [3:0]        xfer;
	logic [15:0]       lfsr_st;
	int                issued [4];

	raystore dut0 (
		.clk, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.trav0_req(req[0]), .trav0_req_valid(req_valid[0]), .trav0_req_stall(req_stall[0]),
		.trav1_req(req[1]), .trav1_req_valid(req_valid[1]), .trav1_req_stall(req_stall[1]),
		.lcache_req(req[2]), .lcache_req_valid(req_valid[2]), .lcache_req_stall(req_stall[2]),
		.list_req(req[3]), .list_req_valid(req_valid[3]), .list_req_stall(req_stall[3]),
		.trav0_rsp(rsp[0]), .trav0_rsp_valid(rsp_valid[0]), .trav0_rsp_stall(rsp_stall[0]),
		.trav1_rsp(rsp[1]), .trav1_rsp_valid(rsp_valid[1]), .trav1_rsp_stall(rsp_stall[1]),
		.lcache_rsp(rsp[2]), .lcache_rsp_valid(rsp_valid[2]), .lcache_rsp_stall(rsp_stall[2]),
		.list_rsp(rsp[3]), .list_rsp_valid(rsp_valid[3]), .list_rsp_stall(rsp_stall[3])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("FAILED at time %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_st = lfsr_next(lfsr_st);
			r = {r[30:0], lfsr_st[0]};
		end
		return r;
	endfunction

	function automatic ray_pkg::rs_rsp_t expected_rsp(input logic [8:0] id,
			input ray_pkg::rs_tag_t tag);
		ray_pkg::rs_rsp_t r;
		r.tag = tag;
		r.vec = model[id];
		return r;
	endfunction

	function automatic int pending_count();
		int n;
		n = 0;
		for (int c = 0; c < 4; c++) begin
			n += exp_q[c].size();
		end
		return n;
	endfunction

	// stable mid-cycle view of what happens at the coming rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			xfer = req_valid & ~req_stall;
			for (int c = 0; c < 4; c++) begin
				if (rsp_valid[c] && !rsp_stall[c]) begin
					if (exp_q[c].size() == 0) begin
						stop_run($sformatf("client %0d gave a response it never asked for", c));
					end
					check_value($sformatf("rsp[%0d]", c), rsp[c], exp_q[c].pop_front());
				end
			end
			for (int c = 0; c < 4; c++) begin
				if (xfer[c]) begin
					exp_q[c].push_back(expected_rsp(req[c].id, req[c].tag));
				end
			end
			if (wb_ack && wb_we) begin
				if (wb_adr < 3'd6) begin
					stage_model.words[wb_adr] = wb_dat_w;
				end else if (wb_adr == 3'd6) begin
					check_value("req_valid & ~req_stall", xfer, '0);
					model[wb_dat_w[8:0]] = stage_model;
				end
			end
		end
	end

	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
			output logic [31:0] rdat);
		@(posedge clk);
		#2;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		@(negedge clk);
		check_value("wb_ack", wb_ack, 1'b0);
		@(negedge clk);
		check_value("wb_ack", wb_ack, 1'b1);
		rdat = wb_dat_r;
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		// one ack per strobe
		check_value("wb_ack", wb_ack, 1'b0);
	endtask

	task automatic load_ray(input logic [8:0] id, input ray_pkg::ray_vec_u v,
			input logic readback);
		logic [31:0] rd;
		for (int w = 0; w < 6; w++) begin
			wb_access(1'b1, 3'(w), v.words[w], rd);
		end
		if (readback) begin
			for (int w = 0; w < 6; w++) begin
				wb_access(1'b0, 3'(w), 32'h0, rd);
				check_value("wb_dat_r", rd, v.words[w]);
			end
		end
		wb_access(1'b1, 3'd6, {23'h0, id}, rd);
	endtask

	// response must show two cycles after the transfer edge
	task automatic latency_check(input int c, input logic [8:0] id);
		@(posedge clk);
		#2;
		req[c].id = id;
		req[c].tag = {2'(c), 14'h3fff};
		req_valid[c] = 1'b1;
		@(negedge clk);
		check_value($sformatf("req_stall[%0d]", c), req_stall[c], 1'b0);
		@(posedge clk);
		#2;
		req_valid[c] = 1'b0;
		@(negedge clk);
		check_value($sformatf("rsp_valid[%0d]", c), rsp_valid[c], 1'b0);
		@(negedge clk);
		check_value($sformatf("rsp_valid[%0d]", c), rsp_valid[c], 1'b0);
		@(negedge clk);
		check_value($sformatf("rsp_valid[%0d]", c), rsp_valid[c], 1'b1);
		repeat (2) @(negedge clk);
	endtask

	task automatic run_traffic(input int per_client);
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(posedge clk);
			#2;
			busy = 1'b0;
			for (int c = 0; c < 4; c++) begin
				if (req_valid[c] && xfer[c]) begin
					req_valid[c] = 1'b0;
				end
				if (!req_valid[c] && issued[c] < per_client && rand_bits(2) != 0) begin
					req[c].id = loaded_id[rand_bits(5)];
					req[c].tag = {2'(c), 14'(issued[c])};
					req_valid[c] = 1'b1;
					issued[c]++;
				end
				rsp_stall[c] = (rand_bits(2) == 0);
				if (req_valid[c] || issued[c] < per_client) begin
					busy = 1'b1;
				end
			end
		end
	endtask

	// new vectors for already loaded ids while traffic runs
	task automatic commit_stream(input int n);
		ray_pkg::ray_vec_u v;
		logic [8:0]        id;
		for (int k = 0; k < n; k++) begin
			repeat (25 + (k * 7) % 13) @(posedge clk);
			id = loaded_id[(k * 11) % N_LOAD];
			for (int w = 0; w < 6; w++) begin
				v.words[w] = {8'(k), 5'(w), 10'h2a5, id};
			end
			load_ray(id, v, 1'b0);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		stop_run($sformatf("test timed out after %0d cycles", WATCHDOG_CYC));
	end

	initial begin
		ray_pkg::ray_vec_u v;
		int                waited;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		req_valid = '0;
		rsp_stall = '0;
		xfer = '0;
		stage_model = '0;
		lfsr_st = 16'd72;
		for (int c = 0; c < 4; c++) begin
			req[c] = '0;
			issued[c] = 0;
		end
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (int k = 0; k < N_LOAD; k++) begin
			loaded_id[k] = 9'((k * 37 + 5) % 512);
			for (int w = 0; w < 6; w++) begin
				v.words[w] = rand_bits(32);
			end
			load_ray(loaded_id[k], v, 1'b1);
		end

		for (int c = 0; c < 4; c++) begin
			latency_check(c, loaded_id[c * 5]);
		end

		fork
			run_traffic(PER_CLIENT);
			commit_stream(N_COMMIT);
		join

		rsp_stall = '0;
		waited = 0;
		while (pending_count() != 0 && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		// late extra responses would show up here
		repeat (10) @(negedge clk);
		if (pending_count() == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_run($sformatf("%0d expected responses never arrived", pending_count()));
		end
	end

endmodule

`default_nettype wire

//--- raystore.sv
// client order is trav0, trav1, lcache, list, and only the low RAY_ID_W bits of a request id are used
`default_nettype none

module raystore #(
	parameter int RAY_ID_W = ray_pkg::RAY_ID_W_DEF,
	parameter int FIFO_DEPTH = ray_pkg::FIFO_DEPTH_DEF
) (
	input  wire logic             clk,
	input  wire logic             rst_n,

	// loader
	input  wire logic             wb_cyc,
	input  wire logic             wb_stb,
	input  wire logic             wb_we,
	input  wire logic [2:0]       wb_adr,
	input  wire logic [31:0]      wb_dat_w,
	output logic [31:0]           wb_dat_r,
	output logic                  wb_ack,

	// requests
	input  wire ray_pkg::rs_req_t trav0_req,
	input  wire logic             trav0_req_valid,
	output logic                  trav0_req_stall,
	input  wire ray_pkg::rs_req_t trav1_req,
	input  wire logic             trav1_req_valid,
	output logic                  trav1_req_stall,
	input  wire ray_pkg::rs_req_t lcache_req,
	input  wire logic             lcache_req_valid,
	output logic                  lcache_req_stall,
	input  wire ray_pkg::rs_req_t list_req,
	input  wire logic             list_req_valid,
	output logic                  list_req_stall,

	// responses
	output ray_pkg::rs_rsp_t      trav0_rsp,
	output logic                  trav0_rsp_valid,
	input  wire logic             trav0_rsp_stall,
	output ray_pkg::rs_rsp_t      trav1_rsp,
	output logic                  trav1_rsp_valid,
	input  wire logic             trav1_rsp_stall,
	output ray_pkg::rs_rsp_t      lcache_rsp,
	output logic                  lcache_rsp_valid,
	input  wire logic             lcache_rsp_stall,
	output ray_pkg::rs_rsp_t      list_rsp,
	output logic                  list_rsp_valid,
	input  wire logic             list_rsp_stall
);

	wire logic                          mem_we;
	wire logic [RAY_ID_W-1:0]           mem_waddr;
	wire ray_pkg::ray_vec_u             mem_wdata;
	wire logic [RAY_ID_W-1:0]           addr_a;
	wire logic [RAY_ID_W-1:0]           addr_b;
	wire ray_pkg::ray_vec_u             q_a;
	wire ray_pkg::ray_vec_u             q_b;
	wire ray_pkg::rs_grant_t            grant;
	wire logic [ray_pkg::N_CLIENTS-1:0] pipe_full;

	ray_loader_wb #(.RAY_ID_W(RAY_ID_W)) loader (
		.clk, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.mem_we, .mem_waddr, .mem_wdata
	);

	ray_store_arb #(.RAY_ID_W(RAY_ID_W)) arb (
		.clk, .rst_n,
		.req_valid({list_req_valid, lcache_req_valid, trav1_req_valid, trav0_req_valid}),
		.req_id({list_req.id[RAY_ID_W-1:0], lcache_req.id[RAY_ID_W-1:0],
			trav1_req.id[RAY_ID_W-1:0], trav0_req.id[RAY_ID_W-1:0]}),
		.pipe_full,
		.mem_we, .mem_waddr,
		.req_stall({list_req_stall, lcache_req_stall, trav1_req_stall, trav0_req_stall}),
		.grant, .addr_a, .addr_b
	);

	ray_mem #(.RAY_ID_W(RAY_ID_W)) mem (
		.clk, .rst_n,
		.we(mem_we), .addr_a, .addr_b, .wdata(mem_wdata),
		.q_a, .q_b
	);

	client_pipe #(.FIFO_DEPTH(FIFO_DEPTH), .RAY_ID_W(RAY_ID_W)) pipe_trav0 (
		.clk, .rst_n,
		.take(grant.take[0]), .port(grant.port[0]), .req_tag(trav0_req.tag),
		.q_a, .q_b, .rsp_stall(trav0_rsp_stall),
		.full(pipe_full[0]), .rsp(trav0_rsp), .rsp_valid(trav0_rsp_valid)
	);

	client_pipe #(.FIFO_DEPTH(FIFO_DEPTH), .RAY_ID_W(RAY_ID_W)) pipe_trav1 (
		.clk, .rst_n,
		.take(grant.take[1]), .port(grant.port[1]), .req_tag(trav1_req.tag),
		.q_a, .q_b, .rsp_stall(trav1_rsp_stall),
		.full(pipe_full[1]), .rsp(trav1_rsp), .rsp_valid(trav1_rsp_valid)
	);

	client_pipe #(.FIFO_DEPTH(FIFO_DEPTH), .RAY_ID_W(RAY_ID_W)) pipe_lcache (
		.clk, .rst_n,
		.take(grant.take[2]), .port(grant.port[2]), .req_tag(lcache_req.tag),
		.q_a, .q_b, .rsp_stall(lcache_rsp_stall),
		.full(pipe_full[2]), .rsp(lcache_rsp), .rsp_valid(lcache_rsp_valid)
	);

	client_pipe #(.FIFO_DEPTH(FIFO_DEPTH), .RAY_ID_W(RAY_ID_W)) pipe_list (
		.clk, .rst_n,
		.take(grant.take[3]), .port(grant.port[3]), .req_tag(list_req.tag),
		.q_a, .q_b, .rsp_stall(list_rsp_stall),
		.full(pipe_full[3]), .rsp(list_rsp), .rsp_valid(list_rsp_valid)
	);

endmodule

`default_nettype wire

//--- client_pipe.sv
// fixed two-edge path from grant to FIFO write, and full is conservative since it ignores a same-cycle pop
`default_nettype none

module client_pipe #(
	parameter int FIFO_DEPTH = ray_pkg::FIFO_DEPTH_DEF,
	parameter int RAY_ID_W = ray_pkg::RAY_ID_W_DEF
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              take,
	input  wire logic              port,
	input  wire ray_pkg::rs_tag_t  req_tag,
	input  wire ray_pkg::ray_vec_u q_a,
	input  wire ray_pkg::ray_vec_u q_b,
	input  wire logic              rsp_stall,
	output logic                   full,
	output ray_pkg::rs_rsp_t       rsp,
	output logic                   rsp_valid
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 3);

	// s1 lines up with the memory address register, s2 with q
	logic             s1_take;
	logic             s2_take;
	logic             s1_port;
	logic             s2_port;
	ray_pkg::rs_tag_t s1_tag;
	ray_pkg::rs_tag_t s2_tag;

	ray_pkg::rs_rsp_t fifo_mem [FIFO_DEPTH];
	ray_pkg::rs_rsp_t wr_data;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] in_use;
	logic             push;
	logic             pop;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_take <= 1'b0;
			s2_take <= 1'b0;
		end else begin
			s1_take <= take;
			s2_take <= s1_take;
		end
	end

	always_ff @(posedge clk) begin
		s1_port <= port;
		s1_tag <= req_tag;
		s2_port <= s1_port;
		s2_tag <= s1_tag;
	end

	assign wr_data.tag = s2_tag;
	assign wr_data.vec = s2_port ? q_b : q_a;

	assign push = s2_take;
	assign pop = rsp_valid & ~rsp_stall;

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	assign rsp = fifo_mem[rd_ptr];
	assign rsp_valid = (count != '0);

	// stored entries plus reads still in flight
	assign in_use = count + CNT_W'(s1_take) + CNT_W'(s2_take);
	assign full = (in_use >= CNT_W'(FIFO_DEPTH));

	// request id travels in the fixed-width request field
	initial begin
		assert (RAY_ID_W <= ray_pkg::RAY_ID_W_DEF)
			else $fatal(1, "ray id width exceeds the request field");
	end

	// arbiter must respect full two edges earlier
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		push |-> (count < CNT_W'(FIFO_DEPTH)) || pop
	);

endmodule

`default_nettype wire

//--- ray_store_arb.sv
// four clients in fixed order, at most two grants per cycle, and a loader write blocks all grants
`default_nettype none

module ray_store_arb #(
	parameter int RAY_ID_W = ray_pkg::RAY_ID_W_DEF
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic [ray_pkg::N_CLIENTS-1:0] req_valid,
	input  wire logic [ray_pkg::N_CLIENTS-1:0][RAY_ID_W-1:0] req_id,
	input  wire logic [ray_pkg::N_CLIENTS-1:0] pipe_full,
	input  wire logic mem_we,
	input  wire logic [RAY_ID_W-1:0] mem_waddr,
	output logic [ray_pkg::N_CLIENTS-1:0] req_stall,
	output ray_pkg::rs_grant_t grant,
	output logic [RAY_ID_W-1:0] addr_a,
	output logic [RAY_ID_W-1:0] addr_b
);

	localparam int N = ray_pkg::N_CLIENTS;
	localparam int PTR_W = $clog2(N);

	logic [PTR_W-1:0]   rr_ptr;
	logic [N-1:0]       eligible;
	logic [PTR_W-1:0]   idx;
	logic [1:0]         n_got;
	logic [PTR_W-1:0]   sel_a;
	logic [PTR_W-1:0]   sel_b;
	ray_pkg::rs_grant_t pick;

	assign eligible = req_valid & ~pipe_full;

	// walk from the pointer, first hit takes port A and second takes port B
	always_comb begin
		pick = '0;
		sel_a = '0;
		sel_b = '0;
		n_got = '0;
		idx = '0;
		for (int k = 0; k < N; k++) begin
			idx = rr_ptr + PTR_W'(k);
			if (eligible[idx] && n_got < 2'd2) begin
				pick.take[idx] = 1'b1;
				pick.port[idx] = n_got[0];
				if (n_got == 2'd0) begin
					sel_a = idx;
				end else begin
					sel_b = idx;
				end
				n_got = n_got + 2'd1;
			end
		end
	end

	assign grant = mem_we ? '0 : pick;
	assign req_stall = req_valid & ~grant.take;

	// write address wins port A during a commit
	assign addr_a = mem_we ? mem_waddr : req_id[sel_a];
	assign addr_b = req_id[sel_b];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr <= '0;
		end else if (|req_valid && !mem_we) begin
			rr_ptr <= rr_ptr + 1'b1;
		end
	end

	a_two_grants: assert property (
		@(posedge clk) disable iff (!rst_n)
		$countones(grant.take) <= 2
	);

	// never grant into a full response pipe
	a_eligible_only: assert property (
		@(posedge clk) disable iff (!rst_n)
		(grant.take & ~(req_valid & ~pipe_full)) == '0
	);

	a_write_blocks: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_we |-> (grant.take == '0) && (req_stall == req_valid)
	);

endmodule

`default_nettype wire

//--- ray_loader_wb.sv
// classic cycles only with one ack per strobe, and the master must drop stb after ack
`default_nettype none

module ray_loader_wb #(
	parameter int RAY_ID_W = ray_pkg::RAY_ID_W_DEF
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        wb_cyc,
	input  wire logic        wb_stb,
	input  wire logic        wb_we,
	input  wire logic [2:0]  wb_adr,
	input  wire logic [31:0] wb_dat_w,
	output logic [31:0]      wb_dat_r,
	output logic             wb_ack,
	output logic             mem_we,
	output logic [RAY_ID_W-1:0] mem_waddr,
	output ray_pkg::ray_vec_u   mem_wdata
);

	localparam logic [2:0] COMMIT_ADR = 3'd6;

	logic              hit;
	logic              stage_sel;
	logic              commit;
	ray_pkg::ray_vec_u stage;

	// new access seen, ack not yet given
	assign hit = wb_cyc & wb_stb & ~wb_ack;
	assign stage_sel = (wb_adr < 3'(ray_pkg::RAY_WORDS));
	assign commit = hit & wb_we & (wb_adr == COMMIT_ADR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			wb_ack <= hit;
			mem_we <= commit;
		end
	end

	always_ff @(posedge clk) begin
		if (hit && wb_we && stage_sel) begin
			stage.words[wb_adr] <= wb_dat_w;
		end
		if (commit) begin
			mem_waddr <= wb_dat_w[RAY_ID_W-1:0];
		end
		if (hit) begin
			// only staging words read back
			wb_dat_r <= stage_sel ? stage.words[wb_adr] : '0;
		end
	end

	// staged vector is held steady through the write pulse
	assign mem_wdata = stage;

	a_ack_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack
	);

endmodule

`default_nettype wire

//--- ray_mem.sv
// address and read data are both registered so q follows the address by two edges, no write on port B
`default_nettype none

module ray_mem #(
	parameter int RAY_ID_W = ray_pkg::RAY_ID_W_DEF
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              we,
	input  wire logic [RAY_ID_W-1:0] addr_a,
	input  wire logic [RAY_ID_W-1:0] addr_b,
	input  wire ray_pkg::ray_vec_u wdata,
	output ray_pkg::ray_vec_u      q_a,
	output ray_pkg::ray_vec_u      q_b
);

	localparam int DEPTH = 2 ** RAY_ID_W;

	ray_pkg::ray_vec_u   mem [DEPTH];
	logic [RAY_ID_W-1:0] addr_a_q;
	logic [RAY_ID_W-1:0] addr_b_q;

	// port A doubles as the write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr_a] <= wdata;
		end
		addr_a_q <= addr_a;
		addr_b_q <= addr_b;
	end

	// output registers, cleared like a block ram aclr
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q_a <= '0;
			q_b <= '0;
		end else begin
			q_a <= mem[addr_a_q];
			q_b <= mem[addr_b_q];
		end
	end

endmodule

`default_nettype wire

//--- ray_pkg.sv
// float words are carried raw with no arithmetic, and the request id field is fixed at 9 bits
`default_nettype none

package ray_pkg;

	localparam int RAY_ID_W_DEF = 9;
	localparam int FIFO_DEPTH_DEF = 2;

	// two traversal units, leaf cache, list unit
	localparam int N_CLIENTS = 4;
	localparam int RAY_WORDS = 6;

	typedef logic [31:0] ray_word_t;
	typedef logic [15:0] rs_tag_t;

	typedef struct packed {
		ray_word_t x;
		ray_word_t y;
		ray_word_t z;
	} ray_xyz_t;

	typedef struct packed {
		ray_xyz_t origin;
		ray_xyz_t dir;
	} ray_od_t;

	// words[0] is origin x, words[5] is direction z
	typedef union packed {
		ray_word_t [0:RAY_WORDS-1] words;
		ray_od_t                   fields;
	} ray_vec_u;

	typedef struct packed {
		logic [RAY_ID_W_DEF-1:0] id;
		rs_tag_t                 tag;
	} rs_req_t;

	typedef struct packed {
		rs_tag_t  tag;
		ray_vec_u vec;
	} rs_rsp_t;

	// bit i of each field belongs to client i
	typedef struct packed {
		logic [N_CLIENTS-1:0] take;
		logic [N_CLIENTS-1:0] port;
	} rs_grant_t;

endpackage

`default_nettype wire
